// ==== icache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_ctrl (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                core_req,
  input  icache_pkg::core_req_t               core_cmd,
  input  logic                                mem_wait,
  input  logic [icache_pkg::word_bits-1:0]    mem_rdata,
  input  logic                                hit,
  input  icache_pkg::cache_line_u             rd_line,
  input  icache_pkg::cache_line_u             merge_line,
  input  icache_pkg::byte_en_t                merge_en,
  output logic                                core_wait,
  output logic [icache_pkg::word_bits-1:0]    core_rdata,
  output logic                                mem_req,
  output icache_pkg::mem_req_t                mem_cmd,
  output logic [icache_pkg::index_bits-1:0]   lookup_index,
  output logic                                tag_write,
  output logic [icache_pkg::tag_bits-1:0]     tag_value,
  output icache_pkg::byte_en_t                data_write_en,
  output icache_pkg::cache_line_u             data_line,
  output icache_pkg::core_req_t               store_cmd
);
  import icache_pkg::*;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fill,
    st_line,
    st_write,
    st_done
  } state_e;

  state_e               state;
  state_e               state_next;
  core_req_t            req_q;
  logic                 hit_q;
  logic [1:0]           beat_q;
  cache_line_u          fill_line;
  logic [word_bits-1:0] rdata_q;
  logic                 beat_done;
  logic [1:0]           word_sel;

  assign word_sel  = req_q.addr.offset[offset_bits-1 -: 2];
  assign beat_done = mem_req && !mem_wait;

  // ======================================================================
  // state machine
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
      state <= st_idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      st_idle:
        if (core_req)
          state_next = st_lookup;
      st_lookup:
      begin
        // writes always go through, hit or not
        if (req_q.write)
          state_next = st_write;
        else if (hit)
          state_next = st_done;
        else
          state_next = st_fill;
      end
      st_fill:
        if (beat_done && beat_q == 2'(words_per_line - 1))
          state_next = st_line;
      st_line:
        state_next = st_done;
      st_write:
        if (beat_done)
          state_next = st_done;
      st_done:
        state_next = st_idle;
      default:
        state_next = st_idle;
    endcase
  end

  // ======================================================================
  // request, hit and fill registers
  // ======================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      hit_q  <= 1'b0;
      beat_q <= '0;
    end
    else
    begin
      if (state == st_lookup)
      begin
        hit_q  <= hit;
        beat_q <= '0;
      end
      else if (state == st_fill && beat_done)
        beat_q <= beat_q + 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == st_idle && core_req)
      req_q <= core_cmd;
    if (state == st_fill && beat_done)
      fill_line.words[beat_q] <= mem_rdata;
    // requested word, from the array on a hit or the gathered line
    if (state == st_lookup && hit)
      rdata_q <= rd_line.words[word_sel];
    else if (state == st_line)
      rdata_q <= fill_line.words[word_sel];
  end

  // ======================================================================
  // outputs
  // ======================================================================
  assign core_wait  = core_req && (state != st_done);
  assign core_rdata = rdata_q;

  assign mem_req = (state == st_fill) || (state == st_write);

  always_comb
  begin
    mem_cmd.write = (state == st_write);
    mem_cmd.wdata = req_q.wdata;
    if (state == st_write)
    begin
      mem_cmd.size = req_q.size;
      mem_cmd.addr = req_q.addr;
    end
    else
    begin
      // fill beats walk the line one word at a time
      mem_cmd.size = size_word;
      mem_cmd.addr = {req_q.addr.tag, req_q.addr.index, beat_q, 2'b00};
    end
  end

  // a new request reads the arrays while still in idle
  assign lookup_index = (state == st_idle) ? core_cmd.addr.index : req_q.addr.index;
  assign tag_write    = (state == st_line);
  assign tag_value    = req_q.addr.tag;
  assign store_cmd    = req_q;

  always_comb
  begin
    data_write_en = '0;
    data_line     = fill_line;
    if (state == st_line)
      data_write_en = '1;
    else if (state == st_write && beat_done && hit_q)
    begin
      data_write_en = merge_en;
      data_line     = merge_line;
    end
  end

endmodule

`default_nettype wire

// ==== icache_mem_model.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_mem_model (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 mem_req,
  input  icache_pkg::mem_req_t mem_cmd,
  input  logic [31:0]          peek_addr,
  output logic                 mem_wait,
  output logic [31:0]          mem_rdata,
  output logic [31:0]          peek_data,
  output logic [31:0]          read_beats,
  output logic [31:0]          write_beats
);
  import icache_pkg::*;

  localparam int mem_words = 4096;
  localparam int max_stall = 3;

  logic [31:0] mem [mem_words];
  logic [1:0]  lane;
  integer      seed;
  integer      r;
  int          stall_run;

  function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
    return (byte_addr * 32'h9e37_79b9) ^ 32'h3c5a_a5c3;
  endfunction

  initial
  begin
    seed      = 32'h1a64_6766;
    mem_wait  = 1'b0;
    stall_run = 0;
    for (int i = 0; i < mem_words; i++)
      mem[i] = fill_word(32'(i) << 2);
  end

  assign mem_rdata = mem[mem_cmd.addr[13:2]];
  assign peek_data = mem[peek_addr[13:2]];
  assign lane      = mem_cmd.addr[1:0];

  // random wait states, runs capped
  always @(posedge clk)
  begin
    #1;
    r = $random(seed);
    if (!rst && stall_run < max_stall && r[0])
    begin
      mem_wait  = 1'b1;
      stall_run = stall_run + 1;
    end
    else
    begin
      mem_wait  = 1'b0;
      stall_run = 0;
    end
  end

  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      read_beats  <= '0;
      write_beats <= '0;
    end
    else if (mem_req && !mem_wait)
    begin
      if (mem_cmd.write)
      begin
        write_beats <= write_beats + 32'd1;
        case (mem_cmd.size)
          size_byte: mem[mem_cmd.addr[13:2]][{lane, 3'b000} +: 8] = mem_cmd.wdata[7:0];
          size_half: mem[mem_cmd.addr[13:2]][{lane[1], 4'b0000} +: 16] = mem_cmd.wdata[15:0];
          default:   mem[mem_cmd.addr[13:2]] = mem_cmd.wdata;
        endcase
      end
      else
        read_beats <= read_beats + 32'd1;
    end
  end

endmodule

`default_nettype wire

// ==== icache_pkg.sv ====
`default_nettype none

package icache_pkg;

  // ======================================================================
  // sizes
  // ======================================================================
  localparam int addr_width     = 32;
  localparam int tag_bits       = 22;
  localparam int index_bits     = 6;
  localparam int offset_bits    = 4;
  localparam int word_bits      = 32;

  localparam int words_per_line = 4;
  localparam int bytes_per_line = 16;
  localparam int cache_lines    = 64;

  // ======================================================================
  // address and request types
  // ======================================================================
  typedef struct packed {
    logic [tag_bits-1:0]    tag;
    logic [index_bits-1:0]  index;
    logic [offset_bits-1:0] offset;
  } cache_addr_t;

  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_e;

  typedef struct packed {
    logic                 write;
    access_size_e         size;
    cache_addr_t          addr;
    logic [word_bits-1:0] wdata;
  } core_req_t;

  typedef struct packed {
    logic                  write;
    access_size_e          size;
    logic [addr_width-1:0] addr;
    logic [word_bits-1:0]  wdata;
  } mem_req_t;

  // one line, by word for fills and reads, by byte for store merges
  typedef union packed {
    logic [words_per_line-1:0][word_bits-1:0] words;
    logic [bytes_per_line-1:0][7:0]           bytes;
  } cache_line_u;

  typedef logic [bytes_per_line-1:0] byte_en_t;

endpackage

`default_nettype wire

// ==== icache_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_tb;
  import icache_pkg::*;

  localparam int clk_period         = 40;
  localparam int directed_requests  = 17;
  localparam int random_requests    = 200;
  localparam int max_request_cycles = 24;
  localparam int watchdog_cycles    =
    (directed_requests + random_requests) * max_request_cycles + 25;

  logic                 clk;
  logic                 rst;
  logic                 core_req;
  core_req_t            core_cmd;
  logic                 core_wait;
  logic [word_bits-1:0] core_rdata;
  logic                 mem_req;
  mem_req_t             mem_cmd;
  logic                 mem_wait;
  logic [word_bits-1:0] mem_rdata;
  logic [31:0]          peek_data;
  logic [31:0]          read_beats;
  logic [31:0]          write_beats;

  // predicted cache contents, valid and tag per index
  logic                 valid_ref [cache_lines];
  logic [tag_bits-1:0]  tag_ref [cache_lines];
  logic                 req_hit;
  logic [31:0]          req_rd_start;
  logic [31:0]          req_wr_start;
  logic [31:0]          req_addr;
  logic [31:0]          exp_fill_addr;
  logic [31:0]          exp_reads;
  logic [31:0]          exp_writes;
  integer               seed;

  icache_top i_icache_top (.*);

  icache_mem_model i_mem_model (.*, .peek_addr(req_addr));

  assign req_addr      = core_cmd.addr;
  assign exp_fill_addr = {req_addr[31:4], 4'b0000} + ((read_beats - req_rd_start) << 2);
  assign exp_reads     = (core_cmd.write || req_hit) ? 32'd0 : 32'd4;
  assign exp_writes    = core_cmd.write ? 32'd1 : 32'd0;

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    stop_run($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
  endtask

  // ======================================================================
  // checks
  // ======================================================================
  assert property (@(posedge clk) rst |-> !core_wait && !mem_req)
    else stop_run("core_wait or mem_req high during reset");

  assert property (@(posedge clk) disable iff (rst)
    core_req && !core_wait && !core_cmd.write |-> core_rdata == peek_data)
    else report_mismatch("core_rdata", $sampled(core_rdata), $sampled(peek_data));

  assert property (@(posedge clk) disable iff (rst)
    $rose(core_req) && !core_cmd.write && req_hit |-> ##2 (core_req && !core_wait))
    else stop_run("read hit did not complete two cycles after the request");

  assert property (@(posedge clk) disable iff (rst)
    core_req && !core_cmd.write && req_hit |-> !mem_req)
    else stop_run("memory request seen during a read hit");

  // fill beats walk the line in order
  assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_cmd.write |-> mem_cmd.addr == exp_fill_addr)
    else report_mismatch("mem_cmd.addr", $sampled(mem_cmd.addr), $sampled(exp_fill_addr));

  // fill beats are whole words
  assert property (@(posedge clk) disable iff (rst)
    mem_req && !mem_cmd.write |-> mem_cmd.size == size_word)
    else report_mismatch("mem_cmd.size", 32'($sampled(mem_cmd.size)), 32'(size_word));

  assert property (@(posedge clk) disable iff (rst)
    mem_req && mem_cmd.write |-> mem_cmd.addr == req_addr)
    else report_mismatch("mem_cmd.addr", $sampled(mem_cmd.addr), $sampled(req_addr));

  assert property (@(posedge clk) disable iff (rst)
    mem_req && mem_cmd.write |-> mem_cmd.size == core_cmd.size)
    else report_mismatch("mem_cmd.size", 32'($sampled(mem_cmd.size)),
                         32'($sampled(core_cmd.size)));

  assert property (@(posedge clk) disable iff (rst)
    mem_req && mem_cmd.write |-> mem_cmd.wdata == core_cmd.wdata)
    else report_mismatch("mem_cmd.wdata", $sampled(mem_cmd.wdata), $sampled(core_cmd.wdata));

  assert property (@(posedge clk) disable iff (rst)
    core_req && !core_wait |-> read_beats - req_rd_start == exp_reads)
    else report_mismatch("read beats", $sampled(read_beats - req_rd_start),
                         $sampled(exp_reads));

  assert property (@(posedge clk) disable iff (rst)
    core_req && !core_wait |-> write_beats - req_wr_start == exp_writes)
    else report_mismatch("write beats", $sampled(write_beats - req_wr_start),
                         $sampled(exp_writes));

  // ======================================================================
  // stimulus
  // ======================================================================
  task automatic run_request(input logic write, input access_size_e size,
                             input logic [31:0] addr, input logic [31:0] wdata);
    cache_addr_t a;
    a              = addr;
    req_hit        = valid_ref[a.index] && (tag_ref[a.index] == a.tag);
    req_rd_start   = read_beats;
    req_wr_start   = write_beats;
    core_cmd.write = write;
    core_cmd.size  = size;
    core_cmd.addr  = a;
    core_cmd.wdata = wdata;
    core_req       = 1'b1;
    do
      @(negedge clk);
    while (core_wait);
    @(posedge clk);
    #1;
    core_req = 1'b0;
    // only a read miss allocates
    if (!write && !req_hit)
    begin
      valid_ref[a.index] = 1'b1;
      tag_ref[a.index]   = a.tag;
    end
    @(posedge clk);
    #1;
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial
  begin
    #(watchdog_cycles * clk_period);
    stop_run("watchdog expired before all requests completed");
  end

  initial
  begin
    logic [31:0]  r_addr;
    logic [31:0]  r_kind;
    access_size_e r_size;
    seed         = 32'h1a64_6766;
    rst          = 1'b1;
    core_req     = 1'b0;
    core_cmd     = '0;
    req_hit      = 1'b0;
    req_rd_start = '0;
    req_wr_start = '0;
    for (int i = 0; i < cache_lines; i++)
    begin
      valid_ref[i] = 1'b0;
      tag_ref[i]   = '0;
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(posedge clk);
    #1;

    // cold miss, then every word of the line hits
    run_request(1'b0, size_word, 32'h0000_0140, '0);
    for (int w = 0; w < 4; w++)
      run_request(1'b0, size_word, 32'h0000_0140 + 32'(4 * w), '0);

    // partial writes into the cached line, read back
    run_request(1'b1, size_byte, 32'h0000_0145, 32'h0000_00a7);
    run_request(1'b1, size_half, 32'h0000_014a, 32'h0000_b3c1);
    run_request(1'b1, size_word, 32'h0000_014c, 32'h1234_5678);
    for (int w = 1; w < 4; w++)
      run_request(1'b0, size_word, 32'h0000_0140 + 32'(4 * w), '0);

    // write miss leaves the line out
    run_request(1'b1, size_word, 32'h0000_2380, 32'hcafe_0042);
    run_request(1'b0, size_word, 32'h0000_2384, '0);

    // same index, different tags
    run_request(1'b0, size_word, 32'h0000_1240, '0);
    run_request(1'b0, size_word, 32'h0000_3240, '0);
    run_request(1'b0, size_word, 32'h0000_1240, '0);
    run_request(1'b0, size_word, 32'h0000_3240, '0);

    for (int n = 0; n < random_requests; n++)
    begin
      r_addr = $random(seed);
      r_kind = $random(seed);
      r_size = access_size_e'(2'(r_kind[15:0] % 16'd3));
      if (r_size == size_half)
        r_addr[0] = 1'b0;
      else if (r_size == size_word)
        r_addr[1:0] = 2'b00;
      run_request(r_kind[31], r_kind[31] ? r_size : size_word,
                  r_addr & 32'h0000_0fff, $random(seed));
    end

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== icache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               core_req,
  input  icache_pkg::core_req_t              core_cmd,
  input  logic                               mem_wait,
  input  logic [icache_pkg::word_bits-1:0]   mem_rdata,
  output logic                               core_wait,
  output logic [icache_pkg::word_bits-1:0]   core_rdata,
  output logic                               mem_req,
  output icache_pkg::mem_req_t               mem_cmd
);
  import icache_pkg::*;

  logic                  hit;
  cache_line_u           rd_line;
  cache_line_u           merge_line;
  byte_en_t              merge_en;
  logic [index_bits-1:0] lookup_index;
  logic                  tag_write;
  logic [tag_bits-1:0]   tag_value;
  byte_en_t              data_write_en;
  cache_line_u           data_line;
  core_req_t             store_cmd;

  icache_ctrl i_icache_ctrl (
    .clk           (clk),
    .rst           (rst),
    .core_req      (core_req),
    .core_cmd      (core_cmd),
    .mem_wait      (mem_wait),
    .mem_rdata     (mem_rdata),
    .hit           (hit),
    .rd_line       (rd_line),
    .merge_line    (merge_line),
    .merge_en      (merge_en),
    .core_wait     (core_wait),
    .core_rdata    (core_rdata),
    .mem_req       (mem_req),
    .mem_cmd       (mem_cmd),
    .lookup_index  (lookup_index),
    .tag_write     (tag_write),
    .tag_value     (tag_value),
    .data_write_en (data_write_en),
    .data_line     (data_line),
    .store_cmd     (store_cmd)
  );

  store_merge i_store_merge (
    .store_cmd  (store_cmd),
    .merge_line (merge_line),
    .merge_en   (merge_en)
  );

  // tag_value is the held request tag, both compared and written
  tag_valid_store i_tag_valid_store (
    .clk          (clk),
    .rst          (rst),
    .lookup_index (lookup_index),
    .lookup_tag   (tag_value),
    .tag_write    (tag_write),
    .tag_value    (tag_value),
    .hit          (hit)
  );

  line_data_store i_line_data_store (
    .clk           (clk),
    .lookup_index  (lookup_index),
    .data_write_en (data_write_en),
    .data_line     (data_line),
    .rd_line       (rd_line)
  );

endmodule

`default_nettype wire

// ==== line_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module line_data_store (
  input  logic                              clk,
  input  logic [icache_pkg::index_bits-1:0] lookup_index,
  input  icache_pkg::byte_en_t              data_write_en,
  input  icache_pkg::cache_line_u           data_line,
  output icache_pkg::cache_line_u           rd_line
);
  import icache_pkg::*;

  cache_line_u line_mem [cache_lines];

  // per-byte write, registered read of the old contents
  always_ff @(posedge clk)
  begin
    for (int i = 0; i < bytes_per_line; i++)
    begin
      if (data_write_en[i])
        line_mem[lookup_index].bytes[i] <= data_line.bytes[i];
    end
    rd_line <= line_mem[lookup_index];
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module icache_tb \
  -f sources.f -o sim_icache \
  && ./obj_dir/sim_icache > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTBENCH PASSED" sim.log && echo "simulation run passed" \
  || { echo "simulation run failed"; exit 1; }

// ==== sources.f ====
icache_pkg.sv
store_merge.sv
tag_valid_store.sv
line_data_store.sv
icache_ctrl.sv
icache_top.sv
icache_mem_model.sv
icache_tb.sv

// ==== store_merge.sv ====
`timescale 1ns/10ps
`default_nettype none

module store_merge (
  input  icache_pkg::core_req_t   store_cmd,
  output icache_pkg::cache_line_u merge_line,
  output icache_pkg::byte_en_t    merge_en
);
  import icache_pkg::*;

  logic [1:0]           word_sel;
  logic [1:0]           byte_sel;
  logic [word_bits-1:0] lane_data;
  logic [3:0]           lane_en;

  assign word_sel = store_cmd.addr.offset[3:2];
  assign byte_sel = store_cmd.addr.offset[1:0];

  // shift into lane position within the word
  always_comb
  begin
    case (store_cmd.size)
      size_byte:
      begin
        lane_data = {24'd0, store_cmd.wdata[7:0]} << {byte_sel, 3'b000};
        lane_en   = 4'b0001 << byte_sel;
      end
      size_half:
      begin
        lane_data = {16'd0, store_cmd.wdata[15:0]} << {byte_sel[1], 4'b0000};
        lane_en   = 4'b0011 << {byte_sel[1], 1'b0};
      end
      default:
      begin
        lane_data = store_cmd.wdata;
        lane_en   = 4'b1111;
      end
    endcase
  end

  // then place the word in the line
  always_comb
  begin
    merge_line                 = '0;
    merge_line.words[word_sel] = lane_data;
    merge_en                   = '0;
    merge_en[{word_sel, 2'b00} +: 4] = lane_en;
  end

endmodule

`default_nettype wire

// ==== tag_valid_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module tag_valid_store (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [icache_pkg::index_bits-1:0] lookup_index,
  input  logic [icache_pkg::tag_bits-1:0]   lookup_tag,
  input  logic                              tag_write,
  input  logic [icache_pkg::tag_bits-1:0]   tag_value,
  output logic                              hit
);
  import icache_pkg::*;

  logic [tag_bits-1:0]    tag_mem [cache_lines];
  logic [cache_lines-1:0] valid;
  logic [tag_bits-1:0]    tag_q;
  logic                   valid_q;

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid   <= '0;
      valid_q <= 1'b0;
    end
    else
    begin
      if (tag_write)
        valid[lookup_index] <= 1'b1;
      valid_q <= valid[lookup_index];
    end
  end

  always_ff @(posedge clk)
  begin
    if (tag_write)
      tag_mem[lookup_index] <= tag_value;
    tag_q <= tag_mem[lookup_index];
  end

  // compare against the registered read
  assign hit = valid_q && (tag_q == lookup_tag);

endmodule

`default_nettype wire
